// File: src/rx_vote_macros.svh
`ifndef RX_VOTE_MACROS_SVH
`define RX_VOTE_MACROS_SVH

// segment layout
`define SEG_BYTES 16
`define SEG_HDR_BYTES 2

// statistics counters
`define CNT_W 32

// apb byte addresses
`define REG_CTRL 8'h00
`define REG_SEG_MAX 8'h04
`define REG_SEG_COUNT 8'h08
`define REG_OK 8'h0C
`define REG_NG 8'h10
`define REG_LOST 8'h14
`define REG_BAD_FRAME 8'h18

`endif

// File: src/rx_vote_pkg.sv
`default_nettype none

`include "rx_vote_macros.svh"

package rx_vote_pkg;

	// one gmii byte per clock
	typedef struct packed {
		logic en;
		logic er;
		logic [7:0] data;
	} gmii_byte_t;

	// frame_good only valid with frame_end
	typedef struct packed {
		logic valid;
		logic [7:0] data;
		logic frame_end;
		logic frame_good;
	} payload_t;

	// first marks the high byte of the segment number
	typedef struct packed {
		logic valid;
		logic first;
		logic [7:0] data;
	} voted_t;

	// copies per frame, 2*code+1
	typedef enum logic [1:0] {
		RED_1,
		RED_3,
		RED_5,
		RED_7
	} redundancy_e;

	typedef struct packed {
		logic [`CNT_W-1:0] seg_count;
		logic [`CNT_W-1:0] ok;
		logic [`CNT_W-1:0] ng;
		logic [`CNT_W-1:0] lost;
		logic [`CNT_W-1:0] bad_frame;
	} stats_t;

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_PREAMBLE,
		EX_PAYLOAD,
		EX_DROP
	} extract_state_e;

	typedef enum logic {
		VT_COLLECT,
		VT_STREAM
	} vote_state_e;

endpackage

`default_nettype wire

// File: src/rx_frame_extract.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_extract (
	input wire clk125MHz,
	input wire rst_n,
	input var rx_vote_pkg::gmii_byte_t rx_in,
	output rx_vote_pkg::payload_t payload
);
	import rx_vote_pkg::*;

	localparam logic [7:0] PRE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;
	// polynomial 0x04C11DB7, bit reversed for lsb-first shifting
	localparam logic [31:0] CRC_POLY_REFL = 32'hEDB88320;
	// residue 0xC704DD7B as it sits in the reflected register
	localparam logic [31:0] CRC_RESIDUE_REFL = 32'hDEBB20E3;

	extract_state_e state;
	logic [31:0] crc;
	logic [3:0][7:0] dly;
	logic [2:0] fill;
	logic er_seen;
	logic out_valid;
	logic out_end;
	logic out_good;
	logic [7:0] out_data;
	logic take_byte;

	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i]) begin
				r = (r >> 1) ^ CRC_POLY_REFL;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	assign take_byte = (state == EX_PAYLOAD) && rx_in.en;

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			state <= EX_IDLE;
			fill <= '0;
			er_seen <= 1'b0;
			out_valid <= 1'b0;
			out_end <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_end <= 1'b0;
			case (state)
				EX_IDLE: begin
					er_seen <= rx_in.en && rx_in.er;
					if (rx_in.en) begin
						if (rx_in.data == PRE_BYTE) begin
							state <= EX_PREAMBLE;
						end else begin
							state <= EX_DROP;
						end
					end
				end
				EX_PREAMBLE: begin
					er_seen <= er_seen | (rx_in.en && rx_in.er);
					fill <= '0;
					if (rx_in.en && rx_in.data == SFD_BYTE) begin
						state <= EX_PAYLOAD;
					end else if (!rx_in.en || rx_in.data != PRE_BYTE) begin
						// no sfd, wait out the rest of the frame
						state <= EX_DROP;
					end
				end
				EX_PAYLOAD: begin
					if (rx_in.en) begin
						er_seen <= er_seen | rx_in.er;
						if (fill != 3'd4) begin
							fill <= fill + 3'd1;
						end
						// line full, oldest byte is payload
						out_valid <= (fill == 3'd4);
					end else begin
						out_end <= 1'b1;
						state <= EX_IDLE;
					end
				end
				default: begin
					if (!rx_in.en) begin
						state <= EX_IDLE;
					end
				end
			endcase
		end
	end

	// crc and delay line
	always_ff @(posedge clk125MHz) begin
		if (state == EX_PREAMBLE) begin
			crc <= '1;
		end else if (take_byte) begin
			crc <= crc_byte(crc, rx_in.data);
		end
		if (take_byte) begin
			dly <= {dly[2:0], rx_in.data};
			out_data <= dly[3];
		end
		if (state == EX_PAYLOAD && !rx_in.en) begin
			out_good <= (crc == CRC_RESIDUE_REFL) && !er_seen && (fill == 3'd4);
		end
	end

	assign payload = '{valid: out_valid, data: out_data, frame_end: out_end,
		frame_good: out_good};

endmodule

`default_nettype wire

// File: src/rx_majority_vote.sv
`timescale 1ns/100ps
`default_nettype none

`include "rx_vote_macros.svh"

module rx_majority_vote (
	input wire clk125MHz,
	input wire rst_n,
	input var rx_vote_pkg::payload_t payload,
	input var rx_vote_pkg::redundancy_e redundancy,
	output rx_vote_pkg::voted_t voted,
	output logic bad_frame
);
	import rx_vote_pkg::*;

	localparam int COPY_BYTES = `SEG_HDR_BYTES + `SEG_BYTES;
	localparam logic [4:0] LAST_IDX = 5'(COPY_BYTES - 1);

	vote_state_e state;
	// ones seen per byte position and bit
	logic [COPY_BYTES-1:0][7:0][2:0] ones;
	logic [4:0] byte_idx;
	logic [3:0] copy_cnt;
	logic [4:0] stream_idx;
	logic [3:0] copies;
	logic length_ok;
	logic [7:0] vote_byte;

	assign copies = {1'b0, redundancy, 1'b1};
	assign length_ok = (byte_idx == '0) && (copy_cnt == copies);

	// majority is more than code, since R/2 rounds down to code
	always_comb begin
		for (int b = 0; b < 8; b++) begin
			vote_byte[b] = ones[stream_idx][b] > {1'b0, redundancy};
		end
	end

	assign voted = '{valid: state == VT_STREAM,
		first: (state == VT_STREAM) && (stream_idx == '0),
		data: vote_byte};

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			state <= VT_COLLECT;
			ones <= '0;
			byte_idx <= '0;
			copy_cnt <= '0;
			stream_idx <= '0;
			bad_frame <= 1'b0;
		end else begin
			bad_frame <= 1'b0;
			case (state)
				VT_COLLECT: begin
					if (payload.valid) begin
						for (int b = 0; b < 8; b++) begin
							if (payload.data[b]) begin
								ones[byte_idx][b] <= ones[byte_idx][b] + 3'd1;
							end
						end
						if (byte_idx == LAST_IDX) begin
							byte_idx <= '0;
							if (copy_cnt != 4'hF) begin
								copy_cnt <= copy_cnt + 4'd1;
							end
						end else begin
							byte_idx <= byte_idx + 5'd1;
						end
					end
					if (payload.frame_end) begin
						byte_idx <= '0;
						copy_cnt <= '0;
						if (payload.frame_good && length_ok) begin
							state <= VT_STREAM;
							stream_idx <= '0;
						end else begin
							bad_frame <= 1'b1;
							ones <= '0;
						end
					end
				end
				default: begin
					// emptied position by position while streaming
					ones[stream_idx] <= '0;
					if (stream_idx == LAST_IDX) begin
						stream_idx <= '0;
						state <= VT_COLLECT;
					end else begin
						stream_idx <= stream_idx + 5'd1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/rx_seg_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "rx_vote_macros.svh"

module rx_seg_checker (
	input wire clk125MHz,
	input wire rst_n,
	input var rx_vote_pkg::voted_t voted,
	input wire bad_frame,
	input wire [15:0] seg_max,
	input wire clear,
	output rx_vote_pkg::stats_t stats
);
	import rx_vote_pkg::*;

	localparam logic [4:0] HDR_POS = 5'(`SEG_HDR_BYTES);
	localparam logic [4:0] LAST_POS = 5'(`SEG_HDR_BYTES + `SEG_BYTES - 1);

	logic [4:0] pos_q;
	logic [4:0] cur_pos;
	logic [15:0] seg_num;
	logic [15:0] expected;
	logic [15:0] seg_next;
	logic [15:0] gap;
	logic [7:0] pat;
	logic mismatch;
	logic have_exp;
	logic last_byte;
	logic byte_bad;

	assign cur_pos = voted.first ? '0 : pos_q;
	assign last_byte = voted.valid && (cur_pos == LAST_POS);
	assign byte_bad = voted.valid && (cur_pos >= HDR_POS) && (voted.data != pat);

	// sequence arithmetic modulo seg_max
	assign seg_next = ({1'b0, seg_num} + 17'd1 >= {1'b0, seg_max}) ? '0 : seg_num + 16'd1;
	assign gap = (seg_num >= expected) ? seg_num - expected : seg_max - expected + seg_num;

	always_ff @(posedge clk125MHz) begin
		if (voted.valid) begin
			if (cur_pos == 5'd0) begin
				seg_num[15:8] <= voted.data;
			end else if (cur_pos == 5'd1) begin
				seg_num[7:0] <= voted.data;
				pat <= voted.data;
			end else begin
				pat <= pat + 8'd1;
			end
		end
		if (last_byte) begin
			expected <= seg_next;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			pos_q <= '0;
			mismatch <= 1'b0;
			have_exp <= 1'b0;
			stats <= '0;
		end else begin
			if (voted.valid) begin
				pos_q <= cur_pos + 5'd1;
				mismatch <= (voted.first ? 1'b0 : mismatch) | byte_bad;
			end
			if (clear) begin
				stats <= '0;
				have_exp <= 1'b0;
			end else begin
				if (last_byte) begin
					stats.seg_count <= stats.seg_count + 1'b1;
					if (mismatch || byte_bad) begin
						stats.ng <= stats.ng + 1'b1;
					end else begin
						stats.ok <= stats.ok + 1'b1;
					end
					// first segment after clear only seeds expected
					if (have_exp && seg_num != expected) begin
						stats.lost <= stats.lost + {{(`CNT_W - 16){1'b0}}, gap};
					end
					have_exp <= 1'b1;
				end
				if (bad_frame) begin
					stats.bad_frame <= stats.bad_frame + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/rx_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "rx_vote_macros.svh"

module rx_apb_regs (
	input wire clk125MHz,
	input wire rst_n,
	input wire [7:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input var rx_vote_pkg::stats_t stats,
	output rx_vote_pkg::redundancy_e redundancy,
	output logic [15:0] seg_max,
	output logic clear
);
	import rx_vote_pkg::*;

	logic access;
	logic addr_hit;
	logic addr_ro;
	logic wr_ok;

	assign access = psel && penable;

	// address decode and read mux
	always_comb begin
		addr_hit = 1'b1;
		addr_ro = 1'b1;
		prdata = '0;
		case (paddr)
			`REG_CTRL: begin
				addr_ro = 1'b0;
				// clear bit 8 always reads 0
				prdata = {30'b0, redundancy};
			end
			`REG_SEG_MAX: begin
				addr_ro = 1'b0;
				prdata = {16'b0, seg_max};
			end
			`REG_SEG_COUNT: prdata = stats.seg_count;
			`REG_OK: prdata = stats.ok;
			`REG_NG: prdata = stats.ng;
			`REG_LOST: prdata = stats.lost;
			`REG_BAD_FRAME: prdata = stats.bad_frame;
			default: addr_hit = 1'b0;
		endcase
	end

	// zero wait states
	assign pready = 1'b1;
	assign pslverr = access && (!addr_hit || (pwrite && addr_ro));
	assign wr_ok = access && pwrite && addr_hit && !addr_ro;

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			redundancy <= RED_3;
			seg_max <= 16'd256;
			clear <= 1'b0;
		end else begin
			clear <= 1'b0;
			if (wr_ok && paddr == `REG_CTRL) begin
				redundancy <= redundancy_e'(pwdata[1:0]);
				clear <= pwdata[8];
			end
			if (wr_ok && paddr == `REG_SEG_MAX) begin
				seg_max <= pwdata[15:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/rx_vote_top.sv
`timescale 1ns/100ps
`default_nettype none

module rx_vote_top (
	input wire clk125MHz,
	input wire rst_n,
	input var rx_vote_pkg::gmii_byte_t rx_in,
	input wire [7:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import rx_vote_pkg::*;

	payload_t payload;
	voted_t voted;
	stats_t stats;
	redundancy_e redundancy;
	logic bad_frame;
	logic [15:0] seg_max;
	logic clear;

	rx_frame_extract i_rx_frame_extract (
		.clk125MHz(clk125MHz),
		.rst_n(rst_n),
		.rx_in(rx_in),
		.payload(payload)
	);

	rx_majority_vote i_rx_majority_vote (
		.clk125MHz(clk125MHz),
		.rst_n(rst_n),
		.payload(payload),
		.redundancy(redundancy),
		.voted(voted),
		.bad_frame(bad_frame)
	);

	rx_seg_checker i_rx_seg_checker (
		.clk125MHz(clk125MHz),
		.rst_n(rst_n),
		.voted(voted),
		.bad_frame(bad_frame),
		.seg_max(seg_max),
		.clear(clear),
		.stats(stats)
	);

	rx_apb_regs i_rx_apb_regs (
		.clk125MHz(clk125MHz),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.stats(stats),
		.redundancy(redundancy),
		.seg_max(seg_max),
		.clear(clear)
	);

endmodule

`default_nettype wire

// File: testbench/rx_vote_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rx_vote_macros.svh"

module rx_vote_tb;
	import rx_vote_pkg::*;

	localparam int COPY_BYTES = `SEG_HDR_BYTES + `SEG_BYTES;
	localparam int GAP_BYTES = 12;
	localparam int APB_TIMEOUT = 16;
	localparam int POLL_LIMIT = 100;

	logic clk125MHz;
	logic rst_n;
	gmii_byte_t rx_in;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	integer seed;
	string test_name;
	logic [7:0] frame_bytes[$];
	// pending corruption as payload index and xor mask
	int flip_idx[$];
	logic [7:0] flip_mask[$];

	rx_vote_top i_rx_vote_top (
		.clk125MHz(clk125MHz),
		.rst_n(rst_n),
		.rx_in(rx_in),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_stat(input string what, input logic [`CNT_W-1:0] expected,
			input logic [`CNT_W-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s %s expected %0d actual %0d",
				test_name, what, expected, actual));
		end
	endtask

	task automatic check_bus(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s %s expected %0b actual %0b",
				test_name, what, expected, actual));
		end
	endtask

	// setup cycle then access until pready
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge clk125MHz);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk125MHz);
		penable <= 1'b1;
		@(negedge clk125MHz);
		while (!pready) begin
			waited++;
			if (waited > APB_TIMEOUT) begin
				abort_run("APB slave never raised pready");
			end
			@(negedge clk125MHz);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk125MHz);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
			input logic exp_err);
		logic [31:0] unused;
		logic err;
		apb_access(1'b1, addr, data, unused, err);
		check_bus($sformatf("pslverr on write 0x%02h", addr), exp_err, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
			input logic exp_err);
		logic err;
		apb_access(1'b0, addr, 32'h0, data, err);
		check_bus($sformatf("pslverr on read 0x%02h", addr), exp_err, err);
	endtask

	task automatic write_ctrl(input redundancy_e red, input logic clr);
		apb_write(`REG_CTRL, {23'b0, clr, 6'b0, red}, 1'b0);
	endtask

	// poll a counter until it reaches target
	task automatic wait_count(input logic [7:0] addr, input logic [`CNT_W-1:0] target);
		logic [31:0] value;
		int polls;
		polls = 0;
		apb_read(addr, value, 1'b0);
		while (value != target) begin
			polls++;
			if (polls > POLL_LIMIT) begin
				abort_run($sformatf("counter at 0x%02h did not reach %0d in time",
					addr, target));
			end
			apb_read(addr, value, 1'b0);
		end
	endtask

	task automatic check_counters(input int seg, input int ok, input int ng, input int lost,
			input int bad);
		logic [31:0] v;
		apb_read(`REG_SEG_COUNT, v, 1'b0);
		check_stat("seg_count", seg, v);
		apb_read(`REG_OK, v, 1'b0);
		check_stat("ok", ok, v);
		apb_read(`REG_NG, v, 1'b0);
		check_stat("ng", ng, v);
		apb_read(`REG_LOST, v, 1'b0);
		check_stat("lost", lost, v);
		apb_read(`REG_BAD_FRAME, v, 1'b0);
		check_stat("bad_frame", bad, v);
	endtask

	// ethernet fcs from the reflected crc-32 complemented at the end
	function automatic logic [31:0] frame_fcs();
		logic [31:0] c;
		c = 32'hFFFFFFFF;
		foreach (frame_bytes[i]) begin
			c = c ^ {24'h0, frame_bytes[i]};
			for (int k = 0; k < 8; k++) begin
				c = (c >> 1) ^ (32'hEDB88320 & {32{c[0]}});
			end
		end
		return ~c;
	endfunction

	task automatic add_flip(input int copy, input int pos, input logic [7:0] mask);
		flip_idx.push_back(copy * COPY_BYTES + pos);
		flip_mask.push_back(mask);
	endtask

	task automatic drive_byte(input logic en, input logic er, input logic [7:0] data);
		@(posedge clk125MHz);
		rx_in <= '{en: en, er: er, data: data};
	endtask

	// er_at below 0 means no line error
	task automatic send_frame(input logic [15:0] seg, input int copies, input logic bad_fcs,
			input int er_at);
		logic [31:0] fcs;
		frame_bytes.delete();
		for (int c = 0; c < copies; c++) begin
			frame_bytes.push_back(seg[15:8]);
			frame_bytes.push_back(seg[7:0]);
			for (int i = 0; i < `SEG_BYTES; i++) begin
				frame_bytes.push_back(seg[7:0] + 8'(i));
			end
		end
		foreach (flip_idx[f]) begin
			frame_bytes[flip_idx[f]] = frame_bytes[flip_idx[f]] ^ flip_mask[f];
		end
		flip_idx.delete();
		flip_mask.delete();
		fcs = frame_fcs();
		if (bad_fcs) begin
			fcs[17] = ~fcs[17];
		end
		// fcs goes out low byte first
		for (int k = 0; k < 4; k++) begin
			frame_bytes.push_back(fcs[8*k +: 8]);
		end
		repeat (7) drive_byte(1'b1, 1'b0, 8'h55);
		drive_byte(1'b1, 1'b0, 8'hD5);
		foreach (frame_bytes[i]) begin
			drive_byte(1'b1, i == er_at, frame_bytes[i]);
		end
		repeat (GAP_BYTES) drive_byte(1'b0, 1'b0, 8'h00);
	endtask

	task automatic test_registers();
		logic [31:0] v;
		test_name = "registers";
		apb_read(`REG_CTRL, v, 1'b0);
		check_stat("ctrl reset", 32'(RED_3), v);
		apb_read(`REG_SEG_MAX, v, 1'b0);
		check_stat("seg_max reset", 256, v);
		check_counters(0, 0, 0, 0, 0);
		apb_write(`REG_OK, 32'h5, 1'b1);
		apb_read(`REG_OK, v, 1'b0);
		check_stat("ok after write", 0, v);
		apb_read(8'h40, v, 1'b1);
	endtask

	task automatic test_clean_stream();
		test_name = "clean_stream";
		write_ctrl(RED_3, 1'b1);
		for (int s = 0; s < 10; s++) begin
			send_frame(16'(s), 3, 1'b0, -1);
		end
		wait_count(`REG_SEG_COUNT, 10);
		check_counters(10, 10, 0, 0, 0);
	endtask

	task automatic test_voting();
		int n;
		int a;
		int b;
		test_name = "voting";
		write_ctrl(RED_5, 1'b1);
		// at most two bad copies per byte so three stay clean
		for (int s = 30; s < 34; s++) begin
			for (int p = 0; p < COPY_BYTES; p++) begin
				n = {$random(seed)} % 3;
				a = {$random(seed)} % 5;
				b = (a + 1 + {$random(seed)} % 4) % 5;
				if (n > 0) begin
					add_flip(a, p, 8'($random(seed)));
				end
				if (n > 1) begin
					add_flip(b, p, 8'($random(seed)));
				end
			end
			send_frame(16'(s), 5, 1'b0, -1);
		end
		wait_count(`REG_SEG_COUNT, 4);
		check_counters(4, 4, 0, 0, 0);
		write_ctrl(RED_3, 1'b1);
		add_flip(0, 7, 8'h08);
		add_flip(2, 7, 8'h08);
		send_frame(16'd34, 3, 1'b0, -1);
		wait_count(`REG_SEG_COUNT, 1);
		check_counters(1, 0, 1, 0, 0);
	endtask

	task automatic test_frame_errors();
		test_name = "frame_errors";
		write_ctrl(RED_3, 1'b1);
		send_frame(16'd40, 3, 1'b1, -1);
		wait_count(`REG_BAD_FRAME, 1);
		send_frame(16'd41, 3, 1'b0, 10);
		wait_count(`REG_BAD_FRAME, 2);
		send_frame(16'd42, 2, 1'b0, -1);
		wait_count(`REG_BAD_FRAME, 3);
		check_counters(0, 0, 0, 0, 3);
		// vote counters must be empty again
		send_frame(16'd43, 3, 1'b0, -1);
		wait_count(`REG_SEG_COUNT, 1);
		check_counters(1, 1, 0, 0, 3);
	endtask

	task automatic test_sequence();
		test_name = "sequence";
		write_ctrl(RED_3, 1'b1);
		send_frame(16'd2, 3, 1'b0, -1);
		send_frame(16'd3, 3, 1'b0, -1);
		send_frame(16'd7, 3, 1'b0, -1);
		wait_count(`REG_SEG_COUNT, 3);
		check_counters(3, 3, 0, 3, 0);
		apb_write(`REG_SEG_MAX, 32'd8, 1'b0);
		write_ctrl(RED_3, 1'b1);
		send_frame(16'd6, 3, 1'b0, -1);
		send_frame(16'd7, 3, 1'b0, -1);
		send_frame(16'd0, 3, 1'b0, -1);
		wait_count(`REG_SEG_COUNT, 3);
		check_counters(3, 3, 0, 0, 0);
	endtask

	task automatic test_clear();
		logic [31:0] v;
		test_name = "clear";
		apb_write(`REG_SEG_MAX, 32'd256, 1'b0);
		// skips 1 to 4 and votes one data byte wrong
		add_flip(0, 9, 8'h40);
		add_flip(1, 9, 8'h40);
		send_frame(16'd5, 3, 1'b0, -1);
		send_frame(16'd1, 2, 1'b0, -1);
		wait_count(`REG_BAD_FRAME, 1);
		check_counters(4, 3, 1, 4, 1);
		write_ctrl(RED_3, 1'b1);
		apb_read(`REG_CTRL, v, 1'b0);
		check_stat("ctrl after clear", 32'(RED_3), v);
		check_counters(0, 0, 0, 0, 0);
		// last number was 5 so 100 only passes as a fresh start
		send_frame(16'd100, 3, 1'b0, -1);
		send_frame(16'd101, 3, 1'b0, -1);
		wait_count(`REG_SEG_COUNT, 2);
		check_counters(2, 2, 0, 0, 0);
	endtask

	initial begin
		seed = 32'hd7a2;
		rst_n <= 1'b0;
		rx_in <= '0;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		repeat (10) @(posedge clk125MHz);
		rst_n <= 1'b1;
		test_registers();
		test_clean_stream();
		test_voting();
		test_frame_errors();
		test_sequence();
		test_clear();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: rx_vote.f
+incdir+src
src/rx_vote_pkg.sv
src/rx_frame_extract.sv
src/rx_majority_vote.sv
src/rx_seg_checker.sv
src/rx_apb_regs.sv
src/rx_vote_top.sv
testbench/rx_vote_tb.sv

// File: Bender.yml
package:
  name: rx_vote

sources:
  - include_dirs:
      - src
    files:
      - src/rx_vote_pkg.sv
      - src/rx_frame_extract.sv
      - src/rx_majority_vote.sv
      - src/rx_seg_checker.sv
      - src/rx_apb_regs.sv
      - src/rx_vote_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/rx_vote_tb.sv
